// File: mem_error_config.svh
// Memory error logger width settings
// Address and data bus widths shared by the packages and the top level

`ifndef MEM_ERROR_CONFIG_SVH
`define MEM_ERROR_CONFIG_SVH

// Physical address of a memory cycle
`define MEM_ADDR_W 24
// Internal data bus word
`define IDB_W 16
// Address bits above one bus word
`define MEM_ADDR_HI_W (`MEM_ADDR_W - `IDB_W)

`endif

// File: cpu_bus_pkg.sv
// CPU bus types
// Words as they appear on the memory address lines and the internal data bus

`include "mem_error_config.svh"

package cpu_bus_pkg;

  // Full physical address
  // Driven on lbd during every memory cycle
  typedef logic [`MEM_ADDR_W-1:0] phys_addr_t;

  // One internal data bus word
  // Register read back, shared bus, ORed drivers
  typedef logic [`IDB_W-1:0] idb_word_t;

endpackage : cpu_bus_pkg

// File: mem_error_pkg.sv
// Memory error capture word layouts
// Status word (PES) and address word (PEA) as software sees them on the bus

`include "mem_error_config.svh"

package mem_error_pkg;

  // Fixed one bits in the PES high byte
  localparam logic [2:0] PES_ONES = 3'b111;

  // Status word, MSB first
  typedef struct packed {
    logic                      fetch;    // Failing cycle was an instruction fetch
    logic                      cgnt_n;   // Bus grant state, active low
    logic [2:0]                ones;     // Always read as one
    logic                      corr_n;   // Corrected error, active low
    logic                      hierr;    // Error in high byte
    logic                      loerr;    // Error in low byte
    logic [`MEM_ADDR_HI_W-1:0] addr_hi;  // Address bits 23..16
  } pes_t;

  // Address word
  // Low part of the failing address only
  typedef struct packed {
    logic [`IDB_W-1:0] addr_lo;  // Address bits 15..0
  } pea_t;

endpackage : mem_error_pkg

// File: error_capture_reg.sv
// Error capture register
// Holds one captured word and drives it onto the data bus when enabled
// Stands in for a pair of octal latches with tri-state outputs

`timescale 1ns/1ps

module error_capture_reg
  import cpu_bus_pkg::*;
  import mem_error_pkg::*;
#(
  parameter type payload_t = pea_t  // Word layout held here
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      capture,  // Load strobe from the controller
  input  payload_t  d,        // Word to capture
  input  logic      oe,       // Read enable
  output idb_word_t bus       // Own bus word, zero when idle
);

  payload_t q;  // Captured word

  // Load on capture only
  // Contents survive the lock clear and any number of reads
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;  // Reads as zero after reset
    end else if (capture) begin
      q <= d;
    end
  end

  // Output gating
  // Zero instead of high impedance so the top level can OR the drivers
  always_comb begin
    if (oe) begin
      bus = idb_word_t'(q);  // Same width, plain bit copy
    end else begin
      bus = '0;
    end
  end

endmodule : error_capture_reg

// File: error_latch_ctrl.sv
// Memory error latch controller
// Qualifies error events, makes the capture strobes, holds the error lock
// and decodes the read strobes into register output enables

`timescale 1ns/1ps

module error_latch_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic rdata,        // Read data strobe of the memory cycle
  input  logic rerr_n,       // Remote memory error
  input  logic lerr_n,       // Local error
  input  logic bcgnt,        // CPU owns the bus
  input  logic blockl_ext,   // Lock held by another board
  input  logic test,         // Forced capture
  input  logic mr_n,         // Master clear, sampled on clk
  input  logic ps_n,         // Read status word
  input  logic pa_n,         // Read address word
  output logic capture_pes,  // Load status register
  output logic capture_pea,  // Load address register
  output logic read_pes,     // Status register output enable
  output logic read_pea,     // Address register output enable
  output logic blockl_n      // Lock, active low
);

  logic err_flag;     // Any error source, test included
  logic err_event;    // Error during a CPU read cycle
  logic capture;      // Shared load strobe
  logic lock_clear;   // Status read or master clear
  logic lock_q;       // Error lock flip-flop
  logic lock_d;

  // Error sources
  // test lets software exercise the path without a real fault
  assign err_flag  = !rerr_n || !lerr_n || test;

  // Only reads that the CPU owns count
  // DMA cycles and write cycles never log
  assign err_event = rdata && bcgnt && err_flag;

  // Capture needs both locks open
  // Uses the registered lock, so a clear in this cycle
  // does not open the gate until the next one
  assign capture   = err_event && !lock_q && !blockl_ext;

  // Both words load on the same edge
  assign capture_pes = capture;
  assign capture_pea = capture;

  // Lock release
  assign lock_clear = !ps_n || !mr_n;  // Reading status acknowledges the error

  // Next lock state
  always_comb begin
    lock_d = lock_q;
    if (lock_clear) begin
      lock_d = 1'b0;  // Clear wins over a new capture
    end else if (capture) begin
      lock_d = 1'b1;
    end
  end

  // Lock register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lock_q <= 1'b0;  // Open after reset
    end else begin
      lock_q <= lock_d;
    end
  end

  assign blockl_n = !lock_q;  // Low while a logged error is pending

  // Read decode
  // No latency, the strobes drive the enables straight through
  assign read_pes = !ps_n;
  assign read_pea = !pa_n;  // Both may be on at once

endmodule : error_latch_ctrl

// File: mem_error_log.sv
// Memory error logging block
// Captures status and address of a failed CPU memory read, locks out
// later captures until software reads the status word, and returns both
// words on the internal data bus

`timescale 1ns/1ps

`include "mem_error_config.svh"

module mem_error_log
  import cpu_bus_pkg::*;
  import mem_error_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rdata,       // Read data strobe
  input  logic       rerr_n,      // Remote memory error
  input  logic       lerr_n,      // Local error
  input  logic       bcgnt,       // CPU holds the bus
  input  logic       blockl_ext,  // Lock from another board
  input  logic       test,        // Forced capture
  input  logic       mr_n,        // Master clear
  input  logic       ps_n,        // Read status strobe
  input  logic       pa_n,        // Read address strobe
  input  phys_addr_t lbd,         // Address of the cycle
  input  logic       fetch,
  input  logic       cgnt_n,
  input  logic       corr_n,
  input  logic       hierr,
  input  logic       loerr,
  output logic       blockl_n,    // Lock, active low
  output idb_word_t  idb          // Data bus word
);

  pes_t      pes_d;        // Status word as it would be captured now
  pea_t      pea_d;        // Address word as it would be captured now
  logic      capture_pes;
  logic      capture_pea;
  logic      read_pes;
  logic      read_pea;
  idb_word_t pes_bus;      // Status register bus driver
  idb_word_t pea_bus;      // Address register bus driver

  // Status word packing
  always_comb begin
    pes_d         = '0;
    pes_d.fetch   = fetch;
    pes_d.cgnt_n  = cgnt_n;
    pes_d.ones    = PES_ONES;  // Tied high on the board
    pes_d.corr_n  = corr_n;
    pes_d.hierr   = hierr;
    pes_d.loerr   = loerr;
    pes_d.addr_hi = lbd[`MEM_ADDR_W-1 -: `MEM_ADDR_HI_W];  // Top address byte
  end

  // Address word packing
  assign pea_d.addr_lo = lbd[`IDB_W-1:0];

  // Strobe decode and lock
  error_latch_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .rdata       (rdata),
    .rerr_n      (rerr_n),
    .lerr_n      (lerr_n),
    .bcgnt       (bcgnt),
    .blockl_ext  (blockl_ext),
    .test        (test),
    .mr_n        (mr_n),
    .ps_n        (ps_n),
    .pa_n        (pa_n),
    .capture_pes (capture_pes),
    .capture_pea (capture_pea),
    .read_pes    (read_pes),
    .read_pea    (read_pea),
    .blockl_n    (blockl_n)
  );

  // PES register
  error_capture_reg #(.payload_t(pes_t)) u_pes_reg (
    .clk     (clk),
    .arst_n  (arst_n),
    .capture (capture_pes),
    .d       (pes_d),
    .oe      (read_pes),
    .bus     (pes_bus)
  );

  // PEA register
  error_capture_reg #(.payload_t(pea_t)) u_pea_reg (
    .clk     (clk),
    .arst_n  (arst_n),
    .capture (capture_pea),
    .d       (pea_d),
    .oe      (read_pea),
    .bus     (pea_bus)
  );

  // Wired bus
  // Both strobes low gives the OR of the two words, like the board
  assign idb = pes_bus | pea_bus;

endmodule : mem_error_log

// File: mem_error_log_properties.sv
// Memory error logger properties
// Concurrent checks on the error lock, bound into the latch controller

`timescale 1ns/1ps

module mem_error_log_properties (
  input logic clk,
  input logic arst_n,
  input logic capture,   // Load strobe, status side
  input logic blockl_n,  // Lock, active low
  input logic ps_n,
  input logic mr_n
);

  // Lock only sets from a capture one edge earlier
  a_lock_from_capture : assert property (@(posedge clk) disable iff (!arst_n)
    $fell(blockl_n) |-> $past(capture))
    else $error("lock set without a capture in the previous cycle");

  // Gate closed while an error is pending
  a_no_capture_locked : assert property (@(posedge clk) disable iff (!arst_n)
    capture |-> blockl_n)
    else $error("capture while the lock is set");

  // Capture sets the lock unless a clear arrives with it
  a_capture_locks : assert property (@(posedge clk) disable iff (!arst_n)
    (capture && ps_n && mr_n) |=> !blockl_n)
    else $error("capture not followed by the lock");

  // Status read or master clear always releases
  a_clear_unlocks : assert property (@(posedge clk) disable iff (!arst_n)
    (!ps_n || !mr_n) |=> blockl_n)
    else $error("lock still set after a status read or master clear");

endmodule : mem_error_log_properties

bind error_latch_ctrl mem_error_log_properties u_props (
  .clk      (clk),
  .arst_n   (arst_n),
  .capture  (capture_pes),
  .blockl_n (blockl_n),
  .ps_n     (ps_n),
  .mr_n     (mr_n)
);

// File: tb_mem_error_log.sv
// Memory error logger testbench
// Directed sequences for capture, lock and read paths, then LFSR driven
// random cycles, all compared against a reference model of the block

`timescale 1ns/1ps

`include "mem_error_config.svh"

module tb_mem_error_log;

  localparam int CLK_HALF       = 5;
  localparam int CLK_PERIOD     = 2 * CLK_HALF;
  localparam int RESET_CYCLES   = 4;
  localparam int DIRECTED_MAX   = 100;   // Upper bound on directed cycles
  localparam int NUM_CYCLES     = 3000;  // Random cycles
  localparam int MARGIN_NS      = 1000;
  localparam int TIMEOUT_NS     =
    (RESET_CYCLES + DIRECTED_MAX + NUM_CYCLES) * CLK_PERIOD + MARGIN_NS;

  logic                   clk;
  logic                   arst_n;
  logic                   rdata;
  logic                   rerr_n;
  logic                   lerr_n;
  logic                   bcgnt;
  logic                   blockl_ext;
  logic                   test;
  logic                   mr_n;
  logic                   ps_n;
  logic                   pa_n;
  logic [`MEM_ADDR_W-1:0] lbd;
  logic                   fetch;
  logic                   cgnt_n;
  logic                   corr_n;
  logic                   hierr;
  logic                   loerr;
  logic                   blockl_n;
  logic [`IDB_W-1:0]      idb;

  // Reference model state
  logic                   lock_m;
  logic [`IDB_W-1:0]      pes_m;
  logic [`IDB_W-1:0]      pea_m;

  logic [15:0]            lfsr_state;  // Random source

  mem_error_log i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .rdata      (rdata),
    .rerr_n     (rerr_n),
    .lerr_n     (lerr_n),
    .bcgnt      (bcgnt),
    .blockl_ext (blockl_ext),
    .test       (test),
    .mr_n       (mr_n),
    .ps_n       (ps_n),
    .pa_n       (pa_n),
    .lbd        (lbd),
    .fetch      (fetch),
    .cgnt_n     (cgnt_n),
    .corr_n     (corr_n),
    .hierr      (hierr),
    .loerr      (loerr),
    .blockl_n   (blockl_n),
    .idb        (idb)
  );

  always #CLK_HALF clk = ~clk;

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic rand_bit();
    lfsr_state = {lfsr_state[14:0],
                  lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  // High with probability 2^-n
  function automatic logic rand_all(input int n);
    logic res;
    res = 1'b1;
    for (int i = 0; i < n; i++) begin
      res = res & rand_bit();  // Every bit taken, no short circuit
    end
    return res;
  endfunction

  // Quiet bus cycle, CPU owns the bus
  function automatic void set_idle();
    rdata      = 1'b0;
    rerr_n     = 1'b1;
    lerr_n     = 1'b1;
    bcgnt      = 1'b1;
    blockl_ext = 1'b0;
    test       = 1'b0;
    mr_n       = 1'b1;
    ps_n       = 1'b1;
    pa_n       = 1'b1;
    lbd        = '0;
    fetch      = 1'b0;
    cgnt_n     = 1'b0;
    corr_n     = 1'b0;
    hierr      = 1'b0;
    loerr      = 1'b0;
  endfunction

  function automatic void randomize_inputs();
    logic [31:0] word;
    rdata      = rand_bit();                  // About half
    rerr_n     = ~(rand_bit() & rand_bit());  // Low a quarter
    lerr_n     = ~(rand_bit() & rand_bit());
    bcgnt      = rand_bit() | rand_bit();     // Mostly CPU cycles
    test       = rand_all(5);                 // Rare
    blockl_ext = rand_all(4);
    mr_n       = ~rand_all(5);
    ps_n       = ~rand_all(3);                // Low an eighth
    pa_n       = ~rand_all(3);
    fetch      = rand_bit();
    cgnt_n     = rand_bit();
    corr_n     = rand_bit();
    hierr      = rand_bit();
    loerr      = rand_bit();
    word       = rand_word(`MEM_ADDR_W);
    lbd        = word[`MEM_ADDR_W-1:0];
  endfunction

  // Model of one clock edge, inputs as seen before the edge
  function automatic void update_model();
    logic err_event;
    logic cap;
    err_event = rdata && bcgnt && (!rerr_n || !lerr_n || test);
    cap       = err_event && !lock_m && !blockl_ext;
    if (cap) begin
      pes_m = {fetch, cgnt_n, 3'b111, corr_n, hierr, loerr,
               lbd[`MEM_ADDR_W-1:`IDB_W]};
      pea_m = lbd[`IDB_W-1:0];
    end
    if (!ps_n || !mr_n) begin
      lock_m = 1'b0;  // Clear sees the old lock, so it wins
    end else if (cap) begin
      lock_m = 1'b1;
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic check_outputs(input string where);
    logic [`IDB_W-1:0] exp_idb;
    exp_idb = (ps_n ? '0 : pes_m) | (pa_n ? '0 : pea_m);  // Wired OR of readers
    assert (blockl_n === !lock_m)
      else report_failure($sformatf("%s: blockl_n %b, expected %b", where, blockl_n, !lock_m));
    assert (idb === exp_idb)
      else report_failure($sformatf("%s: idb %h, expected %h", where, idb, exp_idb));
  endtask

  task automatic expect_idb(input logic [`IDB_W-1:0] value, input string what);
    assert (idb === value)
      else report_failure($sformatf("%s: idb %h, expected %h", what, idb, value));
  endtask

  task automatic expect_lock(input logic value, input string what);
    assert (blockl_n === value)
      else report_failure($sformatf("%s: blockl_n %b, expected %b", what, blockl_n, value));
  endtask

  // Read path settles 1 ns after the drive
  task automatic settle();
    #1;
    check_outputs("read path");
  endtask

  task automatic clock_edge();
    @(posedge clk);
    update_model();
    #1;
    check_outputs("after edge");  // Last check before the next drive
  endtask

  task automatic step();
    settle();
    clock_edge();
  endtask

  task automatic read_word(input logic ps, input logic pa,
                           input logic [`IDB_W-1:0] value, input string what);
    set_idle();
    ps_n = ps;
    pa_n = pa;
    settle();
    expect_idb(value, what);
    clock_edge();
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog timeout, run did not finish within %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    lfsr_state = 16'd3;
    lock_m     = 1'b0;
    pes_m      = '0;
    pea_m      = '0;
    set_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_outputs("after reset");

    // Reset state reads zero for every strobe pair
    for (int i = 0; i < 4; i++) begin
      set_idle();
      ps_n = i[0];
      pa_n = i[1];
      settle();
      expect_idb('0, "reset contents");
      expect_lock(1'b1, "reset lock");
      clock_edge();
    end

    // Remote error captures both words
    set_idle();
    rdata  = 1'b1;
    rerr_n = 1'b0;
    lbd    = 24'hA5_1234;
    fetch  = 1'b1;
    corr_n = 1'b1;
    loerr  = 1'b1;
    step();
    expect_lock(1'b0, "lock after capture");
    read_word(1'b1, 1'b0, 16'h1234, "address word");
    read_word(1'b0, 1'b1, 16'hBDA5, "status word");  // Clears the lock
    expect_lock(1'b1, "lock after status read");

    // Local error, then a blocked second error
    set_idle();
    rdata  = 1'b1;
    lerr_n = 1'b0;
    lbd    = 24'h3C_0F0F;
    cgnt_n = 1'b1;
    hierr  = 1'b1;
    step();
    set_idle();
    rdata  = 1'b1;
    rerr_n = 1'b0;
    lbd    = 24'hFF_FFFF;
    step();
    read_word(1'b1, 1'b0, 16'h0F0F, "address held under lock");

    // Status read and new error in one cycle, no capture
    set_idle();
    rdata  = 1'b1;
    rerr_n = 1'b0;
    lbd    = 24'h11_2222;
    ps_n   = 1'b0;
    settle();
    expect_idb(16'h7A3C, "status under lock");
    clock_edge();
    expect_lock(1'b1, "lock after same cycle read");
    read_word(1'b1, 1'b0, 16'h0F0F, "no capture on clearing read");

    // Open again, next error lands
    set_idle();
    rdata  = 1'b1;
    rerr_n = 1'b0;
    lbd    = 24'h11_2222;
    step();
    expect_lock(1'b0, "lock after recapture");
    set_idle();
    mr_n = 1'b0;
    step();
    expect_lock(1'b1, "lock after master clear");
    read_word(1'b0, 1'b0, 16'h3A33, "both words ORed");

    // Unqualified errors
    set_idle();
    rdata  = 1'b1;
    rerr_n = 1'b0;
    bcgnt  = 1'b0;  // DMA owns the bus
    lbd    = 24'h55_5555;
    step();
    expect_lock(1'b1, "error without bus grant");
    set_idle();
    lerr_n = 1'b0;  // No read data strobe
    lbd    = 24'h55_5555;
    step();
    expect_lock(1'b1, "error without rdata");
    set_idle();
    rdata      = 1'b1;
    rerr_n     = 1'b0;
    blockl_ext = 1'b1;
    lbd        = 24'h55_5555;
    step();
    expect_lock(1'b1, "error under external lock");
    read_word(1'b1, 1'b0, 16'h2222, "address after ignored errors");

    // Forced capture
    set_idle();
    rdata = 1'b1;
    test  = 1'b1;
    lbd   = 24'h80_0001;
    step();
    expect_lock(1'b0, "lock after test capture");
    read_word(1'b1, 1'b0, 16'h0001, "test address word");
    read_word(1'b0, 1'b1, 16'h3880, "test status word");
    read_word(1'b1, 1'b1, 16'h0000, "no strobe");

    // Random traffic
    for (int n = 0; n < NUM_CYCLES; n++) begin
      randomize_inputs();
      step();
    end
    set_idle();
    step();

    $display("** PASS **");
    $finish;
  end

endmodule : tb_mem_error_log

// File: compile.f
+incdir+.
cpu_bus_pkg.sv
mem_error_pkg.sv
error_capture_reg.sv
error_latch_ctrl.sv
mem_error_log.sv
mem_error_log_properties.sv
tb_mem_error_log.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory error logger testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_mem_error_log

verilator --binary --timing --assert \
  -f compile.f \
  --top-module "$TOP" \
  -Mdir obj_dir

# Keep going on a nonzero exit so the output is still searched
sim_out=$(./obj_dir/V"$TOP" 2>&1) || true
echo "$sim_out"

if grep -qxF -- "** PASS **" <<< "$sim_out"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
